/* flist.f */
+incdir+hw
hw/lc_trans_pkg.sv
hw/lc_trans_ifs.sv
hw/lc_input_stage.sv
hw/translator_fsm.sv
hw/security_encode_stage.sv
hw/lc_security_translator.sv
verification/lc_trans_props.sv
verification/lc_checker.sv
verification/tb_lc_translator.sv

/* hw/lc_input_stage.sv */
// Stage 1 of the translator, registers the fuse and debug inputs
// Classifies the lifecycle code and reduces the debug masks to single requests

`include "lc_trans_params.svh"

module lc_input_stage (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    otp_valid_i,
  input  lc_trans_pkg::lc_state_t otp_state_i,
  input  logic                    lc_prog_req_i,
  input  lc_trans_pkg::lc_state_t lc_prog_state_i,
  input  logic                    state_error_i,
  input  lc_trans_pkg::lc_tx_t    lc_dft_en_i,
  input  lc_trans_pkg::lc_tx_t    lc_hw_debug_en_i,
  input  logic                    dbg_manuf_enable_i,
  input  lc_trans_pkg::dbg_vec_t  dbg_unlock_level_i,
  input  lc_trans_pkg::dbg_vec_t  dft_en_mask_i,
  input  lc_trans_pkg::dbg_vec_t  dbg_unlock_mask_i,
  input  lc_trans_pkg::dbg_vec_t  cltap_unlock_mask_i,
  lc_dec_if.src                   dec_o
);
  import lc_trans_pkg::*;

  logic      scrap_req;
  logic      lock_req;
  logic      prod_unlock;
  logic      dft_term;
  logic      cltap_term;
  logic      dft_req;
  logic      hw_dbg_req;
  lc_class_e lc_class;

  // ------------------------------------------------------------
  // Request decode
  // ------------------------------------------------------------
  // Lifecycle controller programming SCRAP into the fuses
  assign scrap_req = lc_prog_req_i && (lc_prog_state_i == `LC_ST_SCRAP);
  assign lock_req  = scrap_req || (otp_state_i == `LC_ST_SCRAP) || state_error_i;

  // Level ANDed with each mask, any overlapping bit unlocks
  assign prod_unlock = |(dbg_unlock_level_i & dbg_unlock_mask_i);
  assign dft_term    = |(dbg_unlock_level_i & dft_en_mask_i);
  assign cltap_term  = |(dbg_unlock_level_i & cltap_unlock_mask_i);

  // SCRAP in flight kills both SoC enables
  assign dft_req    = ((lc_dft_en_i == `LC_TX_ON) || dft_term) && !scrap_req;
  assign hw_dbg_req = ((lc_hw_debug_en_i == `LC_TX_ON) || cltap_term) && !scrap_req;

  // Lifecycle class of the fuse state
  always_comb begin
    case (otp_state_i)
      `LC_ST_RAW, `LC_ST_TEST_LOCKED0, `LC_ST_TEST_LOCKED1, `LC_ST_TEST_LOCKED2,
      `LC_ST_TEST_LOCKED3, `LC_ST_TEST_LOCKED4, `LC_ST_TEST_LOCKED5,
      `LC_ST_TEST_LOCKED6: lc_class = LOCKED;
      `LC_ST_TEST_UNLOCKED0, `LC_ST_TEST_UNLOCKED1, `LC_ST_TEST_UNLOCKED2,
      `LC_ST_TEST_UNLOCKED3, `LC_ST_TEST_UNLOCKED4, `LC_ST_TEST_UNLOCKED5,
      `LC_ST_TEST_UNLOCKED6, `LC_ST_TEST_UNLOCKED7: lc_class = UNLOCKED;
      `LC_ST_DEV:      lc_class = DEV;
      // PROD_END behaves like PROD for debug purposes
      `LC_ST_PROD, `LC_ST_PROD_END: lc_class = PROD;
      `LC_ST_RMA:      lc_class = RMA;
      `LC_ST_SCRAP:    lc_class = SCRAP;
      default:         lc_class = INVALID;
    endcase
  end

  // ------------------------------------------------------------
  // Input register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_o.valid        <= 1'b0;
      dec_o.lc_class     <= INVALID;
      dec_o.lock_req     <= 1'b0;
      dec_o.manuf_unlock <= 1'b0;
      dec_o.prod_unlock  <= 1'b0;
      dec_o.dft_req      <= 1'b0;
      dec_o.hw_dbg_req   <= 1'b0;
    end else if (!otp_valid_i) begin
      // Fuse data not valid yet, nothing downstream may act
      dec_o.valid        <= 1'b0;
      dec_o.lc_class     <= INVALID;
      dec_o.lock_req     <= 1'b0;
      dec_o.manuf_unlock <= 1'b0;
      dec_o.prod_unlock  <= 1'b0;
      dec_o.dft_req      <= 1'b0;
      dec_o.hw_dbg_req   <= 1'b0;
    end else begin
      dec_o.valid        <= 1'b1;
      dec_o.lc_class     <= lc_class;
      dec_o.lock_req     <= lock_req;
      dec_o.manuf_unlock <= dbg_manuf_enable_i;
      dec_o.prod_unlock  <= prod_unlock;
      dec_o.dft_req      <= dft_req;
      dec_o.hw_dbg_req   <= hw_dbg_req;
    end
  end

endmodule

/* hw/lc_security_translator.sv */
// Top level of the lifecycle to security state translator
// Three-stage pipeline: input decode, translator FSM, output encode

module lc_security_translator (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // Fuse controller
  input  logic                     otp_valid_i,
  input  lc_trans_pkg::lc_state_t  otp_state_i,
  // Lifecycle controller
  input  logic                     lc_prog_req_i,
  input  lc_trans_pkg::lc_state_t  lc_prog_state_i,
  input  logic                     state_error_i,
  input  lc_trans_pkg::lc_tx_t     lc_dft_en_i,
  input  lc_trans_pkg::lc_tx_t     lc_hw_debug_en_i,
  // Core and SoC debug controls
  input  logic                     dbg_manuf_enable_i,
  input  lc_trans_pkg::dbg_vec_t   dbg_unlock_level_i,
  input  lc_trans_pkg::dbg_vec_t   dft_en_mask_i,
  input  lc_trans_pkg::dbg_vec_t   dbg_unlock_mask_i,
  input  lc_trans_pkg::dbg_vec_t   cltap_unlock_mask_i,
  // Security state of the core
  output lc_trans_pkg::lifecycle_t device_lifecycle_o,
  output logic                     debug_locked_o,
  // SoC debug enables
  output logic                     soc_dft_en_o,
  output logic                     soc_hw_debug_en_o
);

  // Stage buses
  lc_dec_if u_dec_if ();
  trans_if  u_trans_if ();

  // ------------------------------------------------------------
  // Stage 1, input register and decode
  // ------------------------------------------------------------
  lc_input_stage u_input (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .otp_valid_i         (otp_valid_i),
    .otp_state_i         (otp_state_i),
    .lc_prog_req_i       (lc_prog_req_i),
    .lc_prog_state_i     (lc_prog_state_i),
    .state_error_i       (state_error_i),
    .lc_dft_en_i         (lc_dft_en_i),
    .lc_hw_debug_en_i    (lc_hw_debug_en_i),
    .dbg_manuf_enable_i  (dbg_manuf_enable_i),
    .dbg_unlock_level_i  (dbg_unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .dec_o               (u_dec_if.src)
  );

  // Stage 2, translator FSM
  translator_fsm u_fsm (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .dec_i   (u_dec_if.dst),
    .trans_o (u_trans_if.src)
  );

  // Stage 3, registered outputs
  security_encode_stage u_encode (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .trans_i            (u_trans_if.dst),
    .device_lifecycle_o (device_lifecycle_o),
    .debug_locked_o     (debug_locked_o),
    .soc_dft_en_o       (soc_dft_en_o),
    .soc_hw_debug_en_o  (soc_hw_debug_en_o)
  );

endmodule

/* hw/lc_trans_ifs.sv */
// Stage-to-stage buses of the translator pipeline
// Plain strobes and levels, no handshake and no back-pressure

// ------------------------------------------------------------
// Stage 1 to stage 2, decoded lifecycle and debug requests
// ------------------------------------------------------------
interface lc_dec_if;
  import lc_trans_pkg::*;

  // Fuse data valid, qualifies every other field
  logic      valid;
  lc_class_e lc_class;
  // SCRAP request or state error, forces lockdown
  logic      lock_req;
  logic      manuf_unlock;
  logic      prod_unlock;
  // SoC enable requests, already masked by SCRAP
  logic      dft_req;
  logic      hw_dbg_req;

  modport src (
    output valid,
    output lc_class,
    output lock_req,
    output manuf_unlock,
    output prod_unlock,
    output dft_req,
    output hw_dbg_req
  );

  modport dst (
    input valid,
    input lc_class,
    input lock_req,
    input manuf_unlock,
    input prod_unlock,
    input dft_req,
    input hw_dbg_req
  );
endinterface

// ------------------------------------------------------------
// Stage 2 to stage 3, FSM state and delayed requests
// ------------------------------------------------------------
interface trans_if;
  import lc_trans_pkg::*;

  logic         valid;
  trans_state_e state;
  // Requests delayed one cycle to line up with state
  logic         dft_req;
  logic         hw_dbg_req;

  modport src (output valid, output state, output dft_req, output hw_dbg_req);
  modport dst (input valid, input state, input dft_req, input hw_dbg_req);
endinterface

/* hw/lc_trans_params.svh */
// Widths, lifecycle codes and the multi-bit On value for the lifecycle translator
// Included by the package and by every block that decodes raw codes

`ifndef LC_TRANS_PARAMS_SVH
`define LC_TRANS_PARAMS_SVH

// ------------------------------------------------------------
// Widths
// ------------------------------------------------------------
`define LC_ST_W 5
`define DBG_W 64
`define LC_TX_W 4

// Multi-bit enable, only this exact pattern counts as On
`define LC_TX_ON 4'b0101

// ------------------------------------------------------------
// Lifecycle codes reported by the fuse controller
// ------------------------------------------------------------
`define LC_ST_RAW 5'd0
// Test states alternate, unlocked on odd codes and locked on even
`define LC_ST_TEST_UNLOCKED0 5'd1
`define LC_ST_TEST_LOCKED0 5'd2
`define LC_ST_TEST_UNLOCKED1 5'd3
`define LC_ST_TEST_LOCKED1 5'd4
`define LC_ST_TEST_UNLOCKED2 5'd5
`define LC_ST_TEST_LOCKED2 5'd6
`define LC_ST_TEST_UNLOCKED3 5'd7
`define LC_ST_TEST_LOCKED3 5'd8
`define LC_ST_TEST_UNLOCKED4 5'd9
`define LC_ST_TEST_LOCKED4 5'd10
`define LC_ST_TEST_UNLOCKED5 5'd11
`define LC_ST_TEST_LOCKED5 5'd12
`define LC_ST_TEST_UNLOCKED6 5'd13
`define LC_ST_TEST_LOCKED6 5'd14
`define LC_ST_TEST_UNLOCKED7 5'd15
// Mission-mode states
`define LC_ST_DEV 5'd16
`define LC_ST_PROD 5'd17
`define LC_ST_PROD_END 5'd18
`define LC_ST_RMA 5'd19
`define LC_ST_SCRAP 5'd20
// Codes 21 to 31 decode as invalid

`endif

/* hw/lc_trans_pkg.sv */
// Shared types of the lifecycle translator pipeline
// Import it wherever lifecycle codes, debug vectors or FSM states are used

`include "lc_trans_params.svh"

package lc_trans_pkg;

  // ------------------------------------------------------------
  // Plain vectors
  // ------------------------------------------------------------
  // Raw lifecycle code from the fuse controller
  typedef logic [`LC_ST_W-1:0] lc_state_t;

  // Multi-bit enable from the lifecycle controller
  typedef logic [`LC_TX_W-1:0] lc_tx_t;

  // Debug unlock level or one of the SoC masks
  typedef logic [`DBG_W-1:0] dbg_vec_t;

  // ------------------------------------------------------------
  // Enumerations
  // ------------------------------------------------------------
  // Device lifecycle seen by the core
  typedef enum logic [1:0] {
    UNPROVISIONED = 2'b00,
    MANUFACTURING = 2'b01,
    PRODUCTION    = 2'b11
  } lifecycle_t;

  // Lifecycle class after decoding the raw code
  typedef enum logic [2:0] {
    LOCKED,
    UNLOCKED,
    DEV,
    PROD,
    RMA,
    SCRAP,
    INVALID
  } lc_class_e;

  // Translator FSM states
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    NON_DEBUG,
    UNPROV_DEBUG,
    MANUF_NON_DEBUG,
    MANUF_DEBUG,
    PROD_NON_DEBUG,
    PROD_DEBUG
  } trans_state_e;

endpackage

/* hw/security_encode_stage.sv */
// Stage 3 of the translator, encodes the FSM state into the core security state
// Registers the lifecycle, the locked bit and the two SoC debug enables

module security_encode_stage (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  trans_if.dst                     trans_i,
  output lc_trans_pkg::lifecycle_t device_lifecycle_o,
  output logic                     debug_locked_o,
  output logic                     soc_dft_en_o,
  output logic                     soc_hw_debug_en_o
);
  import lc_trans_pkg::*;

  lifecycle_t lifecycle_d;
  logic       locked_d;

  // ------------------------------------------------------------
  // State to security state mapping
  // ------------------------------------------------------------
  always_comb begin
    case (trans_i.state)
      UNPROV_DEBUG: begin
        lifecycle_d = UNPROVISIONED;
        locked_d    = 1'b0;
      end
      MANUF_NON_DEBUG: begin
        lifecycle_d = MANUFACTURING;
        locked_d    = 1'b1;
      end
      MANUF_DEBUG: begin
        lifecycle_d = MANUFACTURING;
        locked_d    = 1'b0;
      end
      PROD_DEBUG: begin
        lifecycle_d = PRODUCTION;
        locked_d    = 1'b0;
      end
      // RESET, IDLE, NON_DEBUG and PROD_NON_DEBUG stay locked
      default: begin
        lifecycle_d = PRODUCTION;
        locked_d    = 1'b1;
      end
    endcase
  end

  // ------------------------------------------------------------
  // Output registers, defaults are production and locked
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_lifecycle_o <= PRODUCTION;
      debug_locked_o     <= 1'b1;
      soc_dft_en_o       <= 1'b0;
      soc_hw_debug_en_o  <= 1'b0;
    end else if (!trans_i.valid) begin
      device_lifecycle_o <= PRODUCTION;
      debug_locked_o     <= 1'b1;
      soc_dft_en_o       <= 1'b0;
      soc_hw_debug_en_o  <= 1'b0;
    end else begin
      device_lifecycle_o <= lifecycle_d;
      debug_locked_o     <= locked_d;
      soc_dft_en_o       <= trans_i.dft_req;
      soc_hw_debug_en_o  <= trans_i.hw_dbg_req;
    end
  end

endmodule

/* hw/translator_fsm.sv */
// Stage 2 of the translator, the security state machine
// Walks RESET, IDLE, then the class state, with a sticky non-debug lockdown

module translator_fsm (
  input  logic  clk_i,
  input  logic  rst_ni,
  lc_dec_if.dst dec_i,
  trans_if.src  trans_o
);
  import lc_trans_pkg::*;

  trans_state_e state_q;
  trans_state_e state_d;

  // ------------------------------------------------------------
  // Next-state logic
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    if (!dec_i.valid) begin
      // Fuse data dropped, restart the walk
      state_d = RESET;
    end else begin
      case (state_q)
        RESET: begin
          state_d = IDLE;
        end
        IDLE: begin
          // Lockdown request wins over any class
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end else begin
            case (dec_i.lc_class)
              LOCKED:   state_d = NON_DEBUG;
              SCRAP:    state_d = NON_DEBUG;
              UNLOCKED: state_d = UNPROV_DEBUG;
              DEV:      state_d = MANUF_NON_DEBUG;
              PROD:     state_d = PROD_NON_DEBUG;
              RMA:      state_d = PROD_DEBUG;
              // Invalid code, wait for a usable one
              default:  state_d = IDLE;
            endcase
          end
        end
        // Only valid going low leaves lockdown
        NON_DEBUG: begin
          state_d = NON_DEBUG;
        end
        UNPROV_DEBUG: begin
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end
        end
        MANUF_NON_DEBUG: begin
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end else if (dec_i.manuf_unlock) begin
            state_d = MANUF_DEBUG;
          end
        end
        MANUF_DEBUG: begin
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end
        end
        PROD_NON_DEBUG: begin
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end else if (dec_i.prod_unlock) begin
            state_d = PROD_DEBUG;
          end
        end
        PROD_DEBUG: begin
          if (dec_i.lock_req) begin
            state_d = NON_DEBUG;
          end
        end
        default: begin
          state_d = RESET;
        end
      endcase
    end
  end

  // ------------------------------------------------------------
  // State and request registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= RESET;
      trans_o.valid      <= 1'b0;
      trans_o.dft_req    <= 1'b0;
      trans_o.hw_dbg_req <= 1'b0;
    end else begin
      state_q            <= state_d;
      // Requests delayed so they line up with the new state
      trans_o.valid      <= dec_i.valid;
      trans_o.dft_req    <= dec_i.dft_req;
      trans_o.hw_dbg_req <= dec_i.hw_dbg_req;
    end
  end

  assign trans_o.state = state_q;

endmodule

/* run_sim.sh */
#!/bin/sh
rm -f build.log sim.log &&
verilator --binary --assert -f flist.f --top-module tb_lc_translator -o sim_tb \
  > build.log 2>&1 &&
./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 ||
  echo "Build or simulation ended with an error, see build.log and sim.log"
cat sim.log 2>/dev/null
grep -q "\*\*\* TEST PASSED \*\*\*" sim.log 2>/dev/null && echo "PASS" ||
  { echo "FAIL"; exit 1; }

/* verification/lc_checker.sv */
// Compares the translator outputs with expected values and counts mismatches
// The testbench calls its tasks at points where the outputs are stable

module lc_checker (
  input lc_trans_pkg::lifecycle_t lifecycle_i,
  input logic                     debug_locked_i,
  input logic                     soc_dft_en_i,
  input logic                     soc_hw_debug_en_i
);
  import lc_trans_pkg::*;

  int val_errs = 0;
  int gap_errs = 0;

  // ------------------------------------------------------------
  // Field compares, each returns 1 on a mismatch
  // ------------------------------------------------------------
  function automatic int lc_mismatch(string name, lifecycle_t exp, lifecycle_t act);
    if (exp !== act) begin
      $display("ERR %s lifecycle: expected %s, actual %s", name, exp.name(), act.name());
      return 1;
    end
    return 0;
  endfunction

  function automatic int bit_mismatch(string name, string field, logic exp, logic act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %b, actual %b", name, field, exp, act);
      return 1;
    end
    return 0;
  endfunction

  // Settled security state at the end of an entry
  task automatic compare_entry(input string name, input lifecycle_t exp_lc,
                               input logic exp_lk, input logic exp_dft, input logic exp_hw);
    val_errs += lc_mismatch(name, exp_lc, lifecycle_i);
    val_errs += bit_mismatch(name, "debug_locked", exp_lk, debug_locked_i);
    val_errs += bit_mismatch(name, "dft_en", exp_dft, soc_dft_en_i);
    val_errs += bit_mismatch(name, "hw_debug_en", exp_hw, soc_hw_debug_en_i);
  endtask

  // While fuse data is invalid everything sits at production, locked, off
  task automatic check_defaults(input string name);
    gap_errs += lc_mismatch({name, " gap"}, PRODUCTION, lifecycle_i);
    gap_errs += bit_mismatch({name, " gap"}, "debug_locked", 1'b1, debug_locked_i);
    gap_errs += bit_mismatch({name, " gap"}, "dft_en", 1'b0, soc_dft_en_i);
    gap_errs += bit_mismatch({name, " gap"}, "hw_debug_en", 1'b0, soc_hw_debug_en_i);
  endtask

endmodule

/* verification/lc_trans_props.sv */
// Concurrent checks on the translator FSM
// Bound into every translator_fsm instance, the fail count is read by the testbench

module lc_trans_props (
  input logic                       clk_i,
  input logic                       rst_ni,
  input lc_trans_pkg::trans_state_e state_i,
  input logic                       valid_i,
  input logic                       lock_req_i
);
  import lc_trans_pkg::*;

  int fail_count = 0;

  // ------------------------------------------------------------
  // FSM properties
  // ------------------------------------------------------------
  // Reset holds the walk at its start
  reset_state_a: assert property (@(posedge clk_i) !rst_ni |=> state_i == RESET)
    else begin
      $error("FSM left RESET while reset was asserted");
      fail_count++;
    end

  // Fuse data dropping restarts the walk
  invalid_restart_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_i |=> state_i == RESET)
    else begin
      $error("FSM did not return to RESET with valid low");
      fail_count++;
    end

  // Lockdown is sticky
  sticky_lock_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == NON_DEBUG && valid_i) |=> state_i == NON_DEBUG)
    else begin
      $error("FSM left NON_DEBUG while valid was high");
      fail_count++;
    end

  // A lock request out of IDLE never opens debug
  idle_lock_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == IDLE && lock_req_i) |=> state_i inside {NON_DEBUG, RESET})
    else begin
      $error("FSM entered a debug state from IDLE with lock_req high");
      fail_count++;
    end

endmodule

bind translator_fsm lc_trans_props u_props (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .state_i    (state_q),
  .valid_i    (dec_i.valid),
  .lock_req_i (dec_i.lock_req)
);

/* verification/tb_lc_translator.sv */
// Testbench of the lifecycle to security state translator
// Applies a table of lifecycle and debug scenarios, lc_checker compares the outputs

`include "lc_trans_params.svh"

module tb_lc_translator;
  import lc_trans_pkg::*;

  typedef struct packed {
    lc_state_t  otp;
    logic       prog_req;
    logic [3:0] err_at;
    lc_tx_t     dft_en;
    lc_tx_t     hw_en;
    logic       manuf;
    dbg_vec_t   level;
    dbg_vec_t   dmask;
    dbg_vec_t   umask;
    dbg_vec_t   cmask;
    lifecycle_t exp_lc;
    logic       exp_lk;
    logic       exp_dft;
    logic       exp_hw;
  } stim_t;

  logic       clk_i;
  logic       rst_ni;
  logic       otp_valid_i;
  logic       lc_prog_req_i;
  logic       state_error_i;
  logic       dbg_manuf_enable_i;
  lc_state_t  otp_state_i;
  lc_state_t  lc_prog_state_i;
  lc_tx_t     lc_dft_en_i;
  lc_tx_t     lc_hw_debug_en_i;
  dbg_vec_t   dbg_unlock_level_i;
  dbg_vec_t   dft_en_mask_i;
  dbg_vec_t   dbg_unlock_mask_i;
  dbg_vec_t   cltap_unlock_mask_i;
  lifecycle_t device_lifecycle_o;
  logic       debug_locked_o;
  logic       soc_dft_en_o;
  logic       soc_hw_debug_en_o;

  stim_t tbl[$];
  string names[$];
  int    cycles = 0;
  int    max_cycles = 0;

  lc_security_translator uut (.*);

  lc_checker u_chk (
    .lifecycle_i       (device_lifecycle_o),
    .debug_locked_i    (debug_locked_o),
    .soc_dft_en_i      (soc_dft_en_o),
    .soc_hw_debug_en_i (soc_hw_debug_en_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // Watchdog sized from the table, 12 cycles per entry plus margin
  always @(posedge clk_i) begin
    cycles++;
    if (max_cycles != 0 && cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  task automatic add_entry(input string name, input lc_state_t otp, input logic prog_req,
                           input logic [3:0] err_at, input lc_tx_t dft_en, input lc_tx_t hw_en,
                           input logic manuf, input dbg_vec_t level, input dbg_vec_t dmask,
                           input dbg_vec_t umask, input dbg_vec_t cmask, input lifecycle_t lc,
                           input logic lk, input logic dft, input logic hw);
    names.push_back(name);
    tbl.push_back({otp, prog_req, err_at, dft_en, hw_en, manuf, level, dmask, umask, cmask,
                   lc, lk, dft, hw});
  endtask

  // ------------------------------------------------------------
  // Stimulus table and entry loop
  // ------------------------------------------------------------
  initial begin
    stim_t e;
    void'($urandom(32'h44a69019));
    rst_ni = 1'b0;
    otp_valid_i = 1'b0;
    otp_state_i = `LC_ST_RAW;
    lc_prog_req_i = 1'b0;
    lc_prog_state_i = `LC_ST_RAW;
    state_error_i = 1'b0;
    lc_dft_en_i = 4'h0;
    lc_hw_debug_en_i = 4'h0;
    dbg_manuf_enable_i = 1'b0;
    dbg_unlock_level_i = 64'h0;
    dft_en_mask_i = 64'h0;
    dbg_unlock_mask_i = 64'h0;
    cltap_unlock_mask_i = 64'h0;

    add_entry("raw", `LC_ST_RAW, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("test_locked", `LC_ST_TEST_LOCKED3, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("test_unlocked", `LC_ST_TEST_UNLOCKED0, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, UNPROVISIONED, 1'b0, 1'b0, 1'b0);
    add_entry("dev", `LC_ST_DEV, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, MANUFACTURING, 1'b1, 1'b0, 1'b0);
    add_entry("prod", `LC_ST_PROD, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("prod_end", `LC_ST_PROD_END, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("rma", `LC_ST_RMA, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b0, 1'b0, 1'b0);
    add_entry("invalid", 5'd25, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("scrap_state", `LC_ST_SCRAP, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    add_entry("dev_manuf", `LC_ST_DEV, 1'b0, 4'd0, 4'h0, 4'h0, 1'b1,
              64'h0, 64'h0, 64'h0, 64'h0, MANUFACTURING, 1'b0, 1'b0, 1'b0);
    add_entry("prod_unlock", `LC_ST_PROD, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h8000_0000_0000_0001, 64'h0, 64'h1, 64'h0, PRODUCTION, 1'b0, 1'b0, 1'b0);
    add_entry("scrap_req", `LC_ST_TEST_UNLOCKED0, 1'b1, 4'd0, `LC_TX_ON, `LC_TX_ON, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b0);
    // Error hits UNPROV_DEBUG and clears early enough for the FSM to see it gone
    add_entry("late_error", `LC_ST_TEST_UNLOCKED2, 1'b0, 4'd4, 4'h0, `LC_TX_ON, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, PRODUCTION, 1'b1, 1'b0, 1'b1);
    // Only the exact On pattern enables, 4'b1010 must not
    add_entry("dft_on", `LC_ST_DEV, 1'b0, 4'd0, `LC_TX_ON, 4'b1010, 1'b0,
              64'h0, 64'h0, 64'h0, 64'h0, MANUFACTURING, 1'b1, 1'b1, 1'b0);
    add_entry("masked_en", `LC_ST_PROD, 1'b0, 4'd0, 4'h0, 4'h0, 1'b0,
              64'h0000_0001_0000_0010, 64'h0000_0001_0000_0000, 64'h0, 64'h30,
              PRODUCTION, 1'b1, 1'b1, 1'b1);
    max_cycles = tbl.size() * 12 + 20;

    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < tbl.size(); i++) begin
      e = tbl[i];
      for (int c = 0; c < 10; c++) begin
        @(posedge clk_i);
        if (c == 0) begin
          // Two-cycle valid gap sends the FSM back to RESET
          otp_valid_i <= 1'b0;
          otp_state_i <= e.otp;
          lc_prog_req_i <= e.prog_req;
          lc_prog_state_i <= e.prog_req ? `LC_ST_SCRAP : `LC_ST_DEV;
          state_error_i <= 1'b0;
          lc_dft_en_i <= e.dft_en;
          lc_hw_debug_en_i <= e.hw_en;
          dbg_manuf_enable_i <= e.manuf;
          dbg_unlock_level_i <= e.level;
          // With a zero level the masks cannot matter
          if (e.level == 64'h0) begin
            dft_en_mask_i <= {$urandom(), $urandom()};
            dbg_unlock_mask_i <= {$urandom(), $urandom()};
            cltap_unlock_mask_i <= {$urandom(), $urandom()};
          end else begin
            dft_en_mask_i <= e.dmask;
            dbg_unlock_mask_i <= e.umask;
            cltap_unlock_mask_i <= e.cmask;
          end
        end
        if (c == 2) otp_valid_i <= 1'b1;
        // Late state error, held two cycles and then cleared
        if (e.err_at != 4'd0 && c == int'(e.err_at)) state_error_i <= 1'b1;
        if (e.err_at != 4'd0 && c == int'(e.err_at) + 2) state_error_i <= 1'b0;
        // Outputs sit at defaults after edges 3 and 4, check the second cycle
        if (c == 4) begin
          @(negedge clk_i);
          u_chk.check_defaults(names[i]);
        end
      end
      @(negedge clk_i);
      u_chk.compare_entry(names[i], e.exp_lc, e.exp_lk, e.exp_dft, e.exp_hw);
    end

    $display("Errors: value %0d, default %0d, assertion %0d", u_chk.val_errs,
             u_chk.gap_errs, uut.u_fsm.u_props.fail_count);
    if (u_chk.val_errs == 0 && u_chk.gap_errs == 0 && uut.u_fsm.u_props.fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
